// File: project.f
hdl/uart_pkg.sv
hdl/baud_gen.sv
hdl/sync_fifo.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart.sv
sim/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the UART testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module uart_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vuart_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: sim/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;
	import uart_pkg::*;

	localparam int DVSR       = 2;
	localparam int OS         = 16;
	localparam int RX_DEPTH   = 4;	// 2**RX_ADDR_W
	localparam int N_FRAMES   = 32;	// frames over all tests, with slack
	localparam int FRAME_CLKS = (12 * OS + 255) * DVSR;	// covers the long stop of test 5
	localparam int LIMIT      = N_FRAMES * FRAME_CLKS + 2000;

	logic              clk;
	logic              reset;
	line_cfg_t         cfg;
	logic [10:0]       dvsr;
	logic              wr_uart;
	logic [DATA_W-1:0] w_data;
	logic              rd_uart;
	logic              tx, rx_line;
	logic              tx_full, rx_empty;
	logic              tx_done_tick, rx_done_tick;
	logic              e_rxof, e_txof;
	rx_word_t          r_word;
	logic              loop_mode;	// rx fed back from tx
	logic              inj_line;	// bit-banged line for inject mode
	rx_word_t          exp_q[$];	// scoreboard of words still to be read
	rx_word_t          exp_head;
	logic              exp_avail;
	logic              txof_allowed, rxof_allowed;
	int                errors, tests_run, tests_failed;
	int                tx_accepted;
	int                tx_sent = 0;
	int                cycles;

	assign rx_line = loop_mode ? tx : inj_line;

	uart #(.DVSR_W(11), .RX_ADDR_W(2), .TX_ADDR_W(2)) dut_i (
		.clk         (clk),
		.reset       (reset),
		.rx          (rx_line),
		.tx          (tx),
		.cfg         (cfg),
		.dvsr        (dvsr),
		.wr_uart     (wr_uart),
		.w_data      (w_data),
		.tx_full     (tx_full),
		.rd_uart     (rd_uart),
		.r_word      (r_word),
		.rx_empty    (rx_empty),
		.tx_done_tick(tx_done_tick),
		.rx_done_tick(rx_done_tick),
		.e_rxof      (e_rxof),
		.e_txof      (e_txof)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
		if (tx_done_tick)
			tx_sent++;

	// head of the receive FIFO must match the scoreboard
	a_rx_word: assert property (@(posedge clk) disable iff (reset)
		!rx_empty |-> (exp_avail && r_word == exp_head))
		else
		begin
			errors++;
			if (!exp_avail)
				$display("unexpected word 0x%h in the receive FIFO", $sampled(r_word));
			else
				$display("ERROR r_word = 0x%h, expected 0x%h", $sampled(r_word), exp_head);
		end

	// a completed frame shows in the receive FIFO one cycle later
	a_rx_push: assert property (@(posedge clk) disable iff (reset) rx_done_tick |=> !rx_empty)
		else
		begin
			errors++;
			$display("receive FIFO still empty after rx_done_tick");
		end

	// tx_done_tick falls inside the stop period
	a_tx_done_line: assert property (@(posedge clk) disable iff (reset) tx_done_tick |-> tx)
		else
		begin
			errors++;
			$display("tx_done_tick raised while the line was low");
		end

	a_txof_sticky: assert property (@(posedge clk) disable iff (reset) e_txof |=> e_txof)
		else
		begin
			errors++;
			$display("e_txof went low after it was set");
		end

	a_rxof_sticky: assert property (@(posedge clk) disable iff (reset) e_rxof |=> e_rxof)
		else
		begin
			errors++;
			$display("e_rxof went low after it was set");
		end

	a_txof_cause: assert property (@(posedge clk) disable iff (reset) e_txof |-> txof_allowed)
		else
		begin
			errors++;
			$display("e_txof set without a transmit overflow");
		end

	a_rxof_cause: assert property (@(posedge clk) disable iff (reset) e_rxof |-> rxof_allowed)
		else
		begin
			errors++;
			$display("e_rxof set without a receive overflow");
		end

	function automatic logic parity_of(input logic [7:0] data, input int nbits,
		input parity_t mode);
		logic p;
		p = 1'b0;
		for (int i = 0; i < nbits; i++)
			p ^= data[i];
		return (mode == par_odd) ? ~p : p;
	endfunction

	task automatic refresh_head();
		exp_avail = (exp_q.size() != 0);
		if (exp_avail)
			exp_head = exp_q[0];
	endtask

	task automatic expect_word(input logic [7:0] data, input logic perr, input logic ferr);
		rx_word_t w;
		w.data       = (cfg.data_bits == 4'd7) ? {1'b0, data[6:0]} : data;
		w.parity_err = perr;
		w.frame_err  = ferr;
		exp_q.push_back(w);
		refresh_head();
	endtask

	task automatic set_line(input logic [3:0] nbits, input parity_t par, input logic [7:0] stop);
		cfg.data_bits  = nbits;
		cfg.parity     = par;
		cfg.stop_ticks = stop;
		cfg.os_ticks   = OS;
		@(negedge clk);	// DUT registers it on this edge
	endtask

	task automatic write_byte(input logic [7:0] data);
		while (tx_full)
			@(negedge clk);	// host holds off
		expect_word(data, 1'b0, 1'b0);
		wr_uart = 1'b1;
		w_data  = data;
		@(negedge clk);
		wr_uart = 1'b0;
		tx_accepted++;
	endtask

	task automatic drain_words(input int n);
		repeat (n)
		begin
			while (rx_empty)
				@(negedge clk);
			rd_uart = 1'b1;
			@(negedge clk);
			rd_uart = 1'b0;
			void'(exp_q.pop_front());
			refresh_head();
		end
	endtask

	task automatic hold_line(input logic level, input int ticks);
		inj_line = level;
		repeat (ticks * DVSR)
			@(negedge clk);
	endtask

	task automatic inject_frame(input logic [7:0] data, input logic bad_parity,
		input logic low_stop);
		int nbits;
		nbits = cfg.data_bits;
		hold_line(1'b0, cfg.os_ticks);	// start bit
		for (int i = 0; i < nbits; i++)
			hold_line(data[i], cfg.os_ticks);
		if (cfg.parity != par_none)
			hold_line(parity_of(data, nbits, cfg.parity) ^ bad_parity, cfg.os_ticks);
		if (low_stop)
		begin
			// low over the stop sample, then high long enough to drop the false start
			hold_line(1'b0, cfg.stop_ticks * 3 / 4);
			hold_line(1'b1, cfg.stop_ticks);
		end
		else
			hold_line(1'b1, cfg.stop_ticks);
	endtask

	task automatic loop_random(input int n);
		fork
			repeat (n)
				write_byte(8'($urandom));
			drain_words(n);
		join
		while (tx_sent != tx_accepted)
			@(negedge clk);	// last stop period over before the format changes
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %0d %s: pass", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_before);
		end
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not complete", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int         err_before;
		int         accepted;
		logic [7:0] data;
		void'($urandom(2562));
		reset          = 1'b1;
		cfg.data_bits  = 4'd8;
		cfg.parity     = par_none;
		cfg.stop_ticks = 8'd16;
		cfg.os_ticks   = OS;
		dvsr           = DVSR;
		wr_uart        = 1'b0;
		w_data         = '0;
		rd_uart        = 1'b0;
		loop_mode      = 1'b1;
		inj_line       = 1'b1;
		txof_allowed   = 1'b0;
		rxof_allowed   = 1'b0;
		exp_avail      = 1'b0;
		exp_head       = '0;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		tx_accepted    = 0;
		repeat (5)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err_before = errors;
		set_line(4'd8, par_none, 8'd16);
		loop_random(8);
		finish_test("8n1 loopback", err_before);

		err_before = errors;
		set_line(4'd7, par_even, 8'd16);
		loop_random(4);
		set_line(4'd8, par_odd, 8'd32);	// two stop bits
		loop_random(4);
		finish_test("7e1 then 8o2 loopback", err_before);

		err_before = errors;
		loop_mode = 1'b0;
		set_line(4'd8, par_even, 8'd16);
		data = 8'($urandom);
		expect_word(data, 1'b1, 1'b0);
		inject_frame(data, 1'b1, 1'b0);
		drain_words(1);
		finish_test("injected parity error", err_before);

		err_before = errors;
		set_line(4'd8, par_none, 8'd16);
		data = 8'($urandom);
		expect_word(data, 1'b0, 1'b1);
		inject_frame(data, 1'b0, 1'b1);
		data = 8'($urandom);
		expect_word(data, 1'b0, 1'b0);
		inject_frame(data, 1'b0, 1'b0);
		drain_words(2);
		finish_test("injected frame error", err_before);

		err_before = errors;
		loop_mode = 1'b1;
		set_line(4'd8, par_none, 8'd255);	// long stop keeps the tx FIFO filled
		accepted = 0;
		while (!tx_full && accepted < 8)
		begin
			write_byte(8'($urandom));
			accepted++;
		end
		txof_allowed = 1'b1;
		wr_uart      = 1'b1;
		w_data       = 8'($urandom);	// rejected, never expected
		@(negedge clk);
		wr_uart = 1'b0;
		assert (e_txof)
			else
			begin
				errors++;
				$display("ERROR e_txof = 0x%h, expected 0x1", e_txof);
			end
		drain_words(accepted);
		while (tx_sent != tx_accepted)
			@(negedge clk);
		finish_test("transmit overflow", err_before);

		err_before = errors;
		loop_mode = 1'b0;
		set_line(4'd8, par_none, 8'd16);
		for (int i = 0; i < RX_DEPTH + 2; i++)
		begin
			data = 8'($urandom);
			if (i < RX_DEPTH)
				expect_word(data, 1'b0, 1'b0);
			else
				rxof_allowed = 1'b1;	// FIFO full, this frame is dropped
			inject_frame(data, 1'b0, 1'b0);
		end
		assert (e_rxof)
			else
			begin
				errors++;
				$display("ERROR e_rxof = 0x%h, expected 0x1", e_rxof);
			end
		drain_words(RX_DEPTH);
		@(negedge clk);
		assert (rx_empty)
			else
			begin
				errors++;
				$display("receive FIFO still holds words after draining its depth");
			end
		finish_test("receive overflow", err_before);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: hdl/uart.sv
`timescale 1ns/1ps

module uart
#(
	parameter int DVSR_W    = 11,
	parameter int RX_ADDR_W = 2,
	parameter int TX_ADDR_W = 2
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rx,
	output logic                        tx,
	input  uart_pkg::line_cfg_t         cfg,
	input  logic [DVSR_W-1:0]           dvsr,	// clocks per oversampling tick
	input  logic                        wr_uart,
	input  logic [uart_pkg::DATA_W-1:0] w_data,
	output logic                        tx_full,
	input  logic                        rd_uart,
	output uart_pkg::rx_word_t          r_word,
	output logic                        rx_empty,
	output logic                        tx_done_tick,
	output logic                        rx_done_tick,
	output logic                        e_rxof,
	output logic                        e_txof
);
	import uart_pkg::*;

	line_cfg_t         cfg_reg;
	logic [DVSR_W-1:0] dvsr_reg;
	logic              tick;
	logic              tx_empty;
	logic              tx_start;
	logic              rx_full;
	logic [DATA_W-1:0] tx_din;
	rx_word_t          rx_word;

	// line setup follows the inputs one cycle later
	always_ff @(posedge clk)
	begin
		cfg_reg  <= cfg;
		dvsr_reg <= dvsr;
	end

	// sticky overflow flags, cleared only by reset
	always_ff @(posedge clk, posedge reset)
		if (reset)
		begin
			e_rxof <= 1'b0;
			e_txof <= 1'b0;
		end
		else
		begin
			if (wr_uart && tx_full)
				e_txof <= 1'b1;
			if (rx_done_tick && rx_full)
				e_rxof <= 1'b1;	// completed frame dropped
		end

	assign tx_start = ~tx_empty;

	baud_gen #(.DVSR_W(DVSR_W)) baud_gen_unit (
		.clk  (clk),
		.reset(reset),
		.dvsr (dvsr_reg),
		.tick (tick)
	);

	uart_rx uart_rx_unit (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg_reg),
		.tick        (tick),
		.rx          (rx),
		.rx_done_tick(rx_done_tick),
		.word        (rx_word)
	);

	sync_fifo #(.payload_t(rx_word_t), .ADDR_W(RX_ADDR_W)) fifo_rx_unit (
		.clk   (clk),
		.reset (reset),
		.wr    (rx_done_tick),
		.w_data(rx_word),
		.rd    (rd_uart),
		.r_data(r_word),
		.empty (rx_empty),
		.full  (rx_full)
	);

	sync_fifo #(.payload_t(logic [DATA_W-1:0]), .ADDR_W(TX_ADDR_W)) fifo_tx_unit (
		.clk   (clk),
		.reset (reset),
		.wr    (wr_uart),
		.w_data(w_data),
		.rd    (tx_done_tick),	// frame sent, drop the head
		.r_data(tx_din),
		.empty (tx_empty),
		.full  (tx_full)
	);

	uart_tx uart_tx_unit (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg_reg),
		.tick        (tick),
		.start       (tx_start),
		.din         (tx_din),
		.tx_done_tick(tx_done_tick),
		.tx          (tx)
	);

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
(
	input  logic                        clk,
	input  logic                        reset,
	input  uart_pkg::line_cfg_t         cfg,
	input  logic                        tick,
	input  logic                        start,
	input  logic [uart_pkg::DATA_W-1:0] din,
	output logic                        tx_done_tick,
	output logic                        tx
);
	import uart_pkg::*;

	typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

	state_t            state_reg, state_next;
	logic [7:0]        s_reg, s_next;	// ticks within the current bit
	logic [3:0]        n_reg, n_next;	// data bits sent so far
	logic [DATA_W-1:0] b_reg, b_next;
	logic              par_reg, par_next;
	logic              tx_reg, tx_next;
	logic [DATA_W-1:0] din_masked;
	logic              bit_end;

	assign din_masked = (cfg.data_bits == 4'd7) ? {1'b0, din[DATA_W-2:0]} : din;
	assign bit_end    = tick && (s_reg == cfg.os_ticks - 8'd1);

	always_ff @(posedge clk, posedge reset)
		if (reset)
		begin
			state_reg <= st_idle;
			s_reg     <= '0;
			n_reg     <= '0;
			tx_reg    <= 1'b1;	// line idles high
		end
		else
		begin
			state_reg <= state_next;
			s_reg     <= s_next;
			n_reg     <= n_next;
			tx_reg    <= tx_next;
		end

	always_ff @(posedge clk)
	begin
		b_reg   <= b_next;
		par_reg <= par_next;
	end

	always_comb
	begin
		state_next   = state_reg;
		s_next       = s_reg;
		n_next       = n_reg;
		b_next       = b_reg;
		par_next     = par_reg;
		tx_done_tick = 1'b0;
		case (state_reg)
			st_idle:
				if (start)
				begin
					state_next = st_start;
					s_next     = '0;
					b_next     = din_masked;
					par_next   = (cfg.parity == par_odd) ? ~^din_masked : ^din_masked;
				end
			st_start:
				if (bit_end)
				begin
					s_next     = '0;
					n_next     = '0;
					state_next = st_data;
				end
				else if (tick)
					s_next = s_reg + 8'd1;
			st_data:
				if (bit_end)
				begin
					s_next = '0;
					b_next = b_reg >> 1;
					if (n_reg == cfg.data_bits - 4'd1)
						state_next = (cfg.parity == par_none) ? st_stop : st_parity;
					else
						n_next = n_reg + 4'd1;
				end
				else if (tick)
					s_next = s_reg + 8'd1;
			st_parity:
				if (bit_end)
				begin
					s_next     = '0;
					state_next = st_stop;
				end
				else if (tick)
					s_next = s_reg + 8'd1;
			st_stop:
				if (tick)
				begin
					if (s_reg == cfg.stop_ticks - 8'd1)
					begin
						tx_done_tick = 1'b1;	// last cycle of the stop period
						state_next   = st_idle;
					end
					else
						s_next = s_reg + 8'd1;
				end
			default:
				state_next = st_idle;
		endcase
	end

	// line level follows the next state so tx stays registered
	always_comb
		case (state_next)
			st_start:
				tx_next = 1'b0;
			st_data:
				tx_next = b_next[0];
			st_parity:
				tx_next = par_next;
			default:
				tx_next = 1'b1;
		endcase

	assign tx = tx_reg;

	a_bit_count: assert property (@(posedge clk) disable iff (reset)
		(state_reg == st_data) |-> (n_reg < cfg.data_bits))
		else $error("uart_tx: bit counter %0d past the data width", n_reg);

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
(
	input  logic                clk,
	input  logic                reset,
	input  uart_pkg::line_cfg_t cfg,
	input  logic                tick,
	input  logic                rx,
	output logic                rx_done_tick,
	output uart_pkg::rx_word_t  word
);
	import uart_pkg::*;

	typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

	state_t            state_reg, state_next;
	logic              rx_meta, rx_sync;	// two-flop synchronizer
	logic [7:0]        s_reg, s_next;	// ticks within the current bit
	logic [3:0]        n_reg, n_next;	// data bits received so far
	logic              done_reg, done_next;
	logic [DATA_W-1:0] b_reg, b_next;
	logic [DATA_W-1:0] shifted;
	logic              par_err_reg, par_err_next;
	logic              frame_err_reg, frame_err_next;
	logic              exp_par;
	logic [7:0]        half_bit;
	logic [7:0]        mid_stop;

	assign shifted  = {rx_sync, b_reg[DATA_W-1:1]};	// LSB arrives first
	assign exp_par  = (cfg.parity == par_odd) ? ~^b_reg : ^b_reg;
	assign half_bit = {1'b0, cfg.os_ticks[7:1]};
	// rest of the last bit plus half of the stop period
	assign mid_stop = half_bit + {1'b0, cfg.stop_ticks[7:1]} - 8'd1;

	always_ff @(posedge clk, posedge reset)
		if (reset)
		begin
			rx_meta   <= 1'b1;
			rx_sync   <= 1'b1;
			state_reg <= st_idle;
			s_reg     <= '0;
			n_reg     <= '0;
			done_reg  <= 1'b0;
		end
		else
		begin
			rx_meta   <= rx;
			rx_sync   <= rx_meta;
			state_reg <= state_next;
			s_reg     <= s_next;
			n_reg     <= n_next;
			done_reg  <= done_next;
		end

	always_ff @(posedge clk)
	begin
		b_reg         <= b_next;
		par_err_reg   <= par_err_next;
		frame_err_reg <= frame_err_next;
	end

	always_comb
	begin
		state_next     = state_reg;
		s_next         = s_reg;
		n_next         = n_reg;
		b_next         = b_reg;
		par_err_next   = par_err_reg;
		frame_err_next = frame_err_reg;
		done_next      = 1'b0;
		case (state_reg)
			st_idle:
				if (!rx_sync)
				begin
					state_next = st_start;
					s_next     = '0;
				end
			st_start:
				if (tick)
				begin
					if (s_reg == half_bit - 8'd1)
					begin
						s_next = '0;
						n_next = '0;
						par_err_next = 1'b0;
						state_next = rx_sync ? st_idle : st_data;	// reject glitches
					end
					else
						s_next = s_reg + 8'd1;
				end
			st_data:
				if (tick)
				begin
					if (s_reg == cfg.os_ticks - 8'd1)
					begin
						s_next = '0;
						if (n_reg == cfg.data_bits - 4'd1)
						begin
							b_next = (cfg.data_bits == 4'd7) ? shifted >> 1 : shifted;
							state_next = (cfg.parity == par_none) ? st_stop : st_parity;
						end
						else
						begin
							b_next = shifted;
							n_next = n_reg + 4'd1;
						end
					end
					else
						s_next = s_reg + 8'd1;
				end
			st_parity:
				if (tick)
				begin
					if (s_reg == cfg.os_ticks - 8'd1)
					begin
						s_next       = '0;
						par_err_next = rx_sync ^ exp_par;
						state_next   = st_stop;
					end
					else
						s_next = s_reg + 8'd1;
				end
			st_stop:
				if (tick)
				begin
					if (s_reg == mid_stop)
					begin
						frame_err_next = ~rx_sync;
						done_next      = 1'b1;
						state_next     = st_idle;
					end
					else
						s_next = s_reg + 8'd1;
				end
			default:
				state_next = st_idle;
		endcase
	end

	assign rx_done_tick = done_reg;	// word regs settle on the same edge

	always_comb
	begin
		word.data       = b_reg;
		word.parity_err = par_err_reg;
		word.frame_err  = frame_err_reg;
	end

	a_width_at_start: assert property (@(posedge clk) disable iff (reset)
		(state_reg == st_idle && !rx_sync) |-> (cfg.data_bits == 4'd7 || cfg.data_bits == 4'd8))
		else $error("uart_rx: unsupported data width %0d", cfg.data_bits);

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
#(
	parameter type payload_t = logic [7:0],
	parameter int  ADDR_W    = 2
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     wr,
	input  payload_t w_data,
	input  logic     rd,
	output payload_t r_data,
	output logic     empty,
	output logic     full
);
	localparam int DEPTH = 2 ** ADDR_W;

	payload_t          mem [DEPTH];
	logic [ADDR_W-1:0] w_ptr, r_ptr;
	logic [ADDR_W-1:0] w_succ, r_succ;
	logic [ADDR_W:0]   count;	// occupancy, tracked for the pointer check
	logic              wr_en, rd_en;

	assign wr_en  = wr && !full;	// writes to a full FIFO are dropped
	assign rd_en  = rd && !empty;
	assign w_succ = w_ptr + 1'b1;
	assign r_succ = r_ptr + 1'b1;
	assign r_data = mem[r_ptr];	// head shows without a read

	always_ff @(posedge clk)
		if (wr_en)
			mem[w_ptr] <= w_data;

	always_ff @(posedge clk, posedge reset)
		if (reset)
		begin
			w_ptr <= '0;
			r_ptr <= '0;
			count <= '0;
			empty <= 1'b1;
			full  <= 1'b0;
		end
		else
		begin
			if (wr_en)
				w_ptr <= w_succ;
			if (rd_en)
				r_ptr <= r_succ;
			if (wr_en && !rd_en)
			begin
				empty <= 1'b0;
				full  <= (w_succ == r_ptr);
				count <= count + 1'b1;
			end
			else if (rd_en && !wr_en)
			begin
				full  <= 1'b0;
				empty <= (r_succ == w_ptr);
				count <= count - 1'b1;
			end
		end

	a_ptr_order: assert property (@(posedge clk) disable iff (reset)
		(count <= DEPTH) && (full == (count == DEPTH)) && (empty == (count == 0)))
		else $error("sync_fifo: pointers crossed, count %0d", count);

endmodule

// File: hdl/baud_gen.sv
`timescale 1ns/1ps

module baud_gen
#(
	parameter int DVSR_W = 11
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic [DVSR_W-1:0] dvsr,	// clocks per oversampling tick
	output logic              tick
);
	logic [DVSR_W-1:0] cnt_reg;
	logic [DVSR_W-1:0] last;

	assign last = dvsr - 1'b1;
	assign tick = (cnt_reg >= last);	// also wraps if dvsr shrinks below the count

	always_ff @(posedge clk, posedge reset)
		if (reset)
			cnt_reg <= '0;
		else if (tick)
			cnt_reg <= '0;
		else
			cnt_reg <= cnt_reg + 1'b1;

	a_dvsr_nonzero: assert property (@(posedge clk) disable iff (reset) dvsr != '0)
		else $error("baud_gen: divisor is zero");

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

	localparam int DATA_W = 8;	// widest data word on the line

	// parity mode of the frame
	typedef enum logic [1:0] {
		par_none = 2'd0,
		par_even = 2'd1,
		par_odd  = 2'd2
	} parity_t;

	// line format, shared by receiver and transmitter
	typedef struct packed {
		logic [3:0] data_bits;	// 7 or 8
		parity_t    parity;
		logic [7:0] stop_ticks;	// 16, 24 or 32 at 16x gives 1, 1.5 or 2 stop bits
		logic [7:0] os_ticks;	// oversampling ticks per bit
	} line_cfg_t;

	// one received frame as stored in the receive FIFO
	typedef struct packed {
		logic [DATA_W-1:0] data;	// right aligned for 7-bit frames
		logic              parity_err;
		logic              frame_err;	// stop sample was low
	} rx_word_t;

endpackage
